//--- src/rrag_settings.svh
`ifndef RRAG_SETTINGS_SVH
`define RRAG_SETTINGS_SVH

// payload width, alias field plus opaque decode body
`define RRAG_N_WIDTH 40

// queue depth, power of two so the pointers wrap on their own
`define RRAG_Q_LENGTH 8
`define RRAG_PTR_WIDTH 3

// branch-predictor alias inside the payload
`define RRAG_ALIAS_MSB 39
`define RRAG_ALIAS_LSB 34

`endif

//--- src/rrag_pkg.sv
package rrag_pkg;

    // modifiable status of a queue slot
    // its width sets the state part of every entry
    typedef enum logic [1:0] {
        // slot free, nothing to pop
        ENT_INVALID  = 2'b00,
        // instruction waiting for rename
        ENT_VALID    = 2'b01,
        // killed by a mispredict, still holds its slot
        // so rename can drop it in order
        ENT_SQUASHED = 2'b10
    } entry_state_e;

    // squash command from branch resolution
    typedef enum logic [1:0] {
        // idle cycle
        SQ_NONE  = 2'b00,
        // flush every waiting entry
        SQ_ALL   = 2'b01,
        // flush only entries on the given predictor alias
        SQ_ALIAS = 2'b10
    } squash_op_e;

endpackage

//--- src/rrag_queue_ctrl.sv
`include "rrag_settings.svh"

module rrag_queue_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    // raw requests from decode and rename
    input  logic                       wr,
    input  logic                       rd,
    input  logic                       clr,
    // qualified enables towards the store
    output logic                       write_en,
    output logic                       read_en,
    output logic [`RRAG_PTR_WIDTH-1:0] wr_ptr,
    output logic [`RRAG_PTR_WIDTH-1:0] rd_ptr,
    // queue status
    output logic                       full,
    output logic                       empty
);

    localparam int PW = `RRAG_PTR_WIDTH;
    localparam int QL = `RRAG_Q_LENGTH;
    // one extra bit so a full queue is distinct from an empty one
    localparam int CW = PW + 1;

    // entries currently held
    logic [CW-1:0] count_q;
    logic [CW-1:0] count_d;

    // status straight from the count
    assign full  = (count_q == CW'(QL));
    assign empty = (count_q == '0);

    // write only with room, read only with data
    // clear wins over both
    assign write_en = wr && !full && !clr;
    assign read_en  = rd && !empty && !clr;

    // next occupancy
    always_comb begin
        count_d = count_q;
        case ({write_en, read_en})
            // push only
            2'b10: count_d = count_q + 1'b1;
            // pop only
            2'b01: count_d = count_q - 1'b1;
            // idle, or push and pop together
            default: count_d = count_q;
        endcase
    end

    // write pointer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
        end else if (write_en) begin
            // power-of-two depth, wraps by overflow
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (clr) begin
            rd_ptr <= '0;
        end else if (read_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // occupancy count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (clr) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

endmodule

//--- src/rrag_queue_store.sv
`include "rrag_settings.svh"

module rrag_queue_store (
    input  logic                       clk,
    input  logic                       arst_n,
    // qualified enables from control
    input  logic                       write_en,
    input  logic                       read_en,
    input  logic                       clr,
    input  logic [`RRAG_PTR_WIDTH-1:0] wr_ptr,
    input  logic [`RRAG_PTR_WIDTH-1:0] rd_ptr,
    // decoded instruction from decode
    input  logic [`RRAG_N_WIDTH-1:0]   din,
    // in-place state rewrite from the squash unit
    input  logic [`RRAG_Q_LENGTH-1:0]  modify_vec,
    input  logic [`RRAG_Q_LENGTH*$bits(rrag_pkg::entry_state_e)-1:0] new_state_vec,
    // every slot's state and alias, for the squash unit
    output logic [`RRAG_Q_LENGTH*$bits(rrag_pkg::entry_state_e)-1:0] old_state_vec,
    output logic [`RRAG_Q_LENGTH*(`RRAG_ALIAS_MSB-`RRAG_ALIAS_LSB+1)-1:0] alias_vec,
    // head entry, state above payload
    output logic [$bits(rrag_pkg::entry_state_e)+`RRAG_N_WIDTH-1:0] dout
);

    localparam int QL = `RRAG_Q_LENGTH;
    localparam int PW = `RRAG_PTR_WIDTH;
    localparam int NW = `RRAG_N_WIDTH;
    localparam int SW = $bits(rrag_pkg::entry_state_e);
    localparam int AW = `RRAG_ALIAS_MSB - `RRAG_ALIAS_LSB + 1;

    // write-once payload per slot
    logic [NW-1:0] payload_q [QL];
    // rewritable status per slot
    rrag_pkg::entry_state_e state_q [QL];

    // payload only changes on a push
    always_ff @(posedge clk) begin
        if (write_en) begin
            payload_q[wr_ptr] <= din;
        end
    end

    // status update per slot
    // push and pop in a slot beat a squash rewrite there
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < QL; i++) begin
                state_q[i] <= rrag_pkg::ENT_INVALID;
            end
        end else if (clr) begin
            // whole queue dropped
            for (int i = 0; i < QL; i++) begin
                state_q[i] <= rrag_pkg::ENT_INVALID;
            end
        end else begin
            for (int i = 0; i < QL; i++) begin
                if (write_en && (wr_ptr == PW'(i))) begin
                    // fresh entry, never squashed on its own write edge
                    state_q[i] <= rrag_pkg::ENT_VALID;
                end else if (read_en && (rd_ptr == PW'(i))) begin
                    // popped entry leaves as it was
                    state_q[i] <= rrag_pkg::ENT_INVALID;
                end else if (modify_vec[i]) begin
                    state_q[i] <= rrag_pkg::entry_state_e'(new_state_vec[i*SW +: SW]);
                end
            end
        end
    end

    // flatten slots for the squash unit
    for (genvar g = 0; g < QL; g++) begin : g_slot
        assign old_state_vec[g*SW +: SW] = state_q[g];
        // alias field sits in the top payload bits
        assign alias_vec[g*AW +: AW] = payload_q[g][`RRAG_ALIAS_MSB:`RRAG_ALIAS_LSB];
    end

    // head entry, combinational from the read pointer
    assign dout = {state_q[rd_ptr], payload_q[rd_ptr]};

endmodule

//--- src/rrag_squash_unit.sv
`include "rrag_settings.svh"

module rrag_squash_unit (
    // command from branch resolution, sampled every cycle
    input  rrag_pkg::squash_op_e                   squash_op,
    input  logic [`RRAG_ALIAS_MSB-`RRAG_ALIAS_LSB:0] squash_alias,
    // current contents of every slot
    input  logic [`RRAG_Q_LENGTH*$bits(rrag_pkg::entry_state_e)-1:0] old_state_vec,
    input  logic [`RRAG_Q_LENGTH*(`RRAG_ALIAS_MSB-`RRAG_ALIAS_LSB+1)-1:0] alias_vec,
    // per-slot rewrite back to the store
    output logic [`RRAG_Q_LENGTH-1:0]               modify_vec,
    output logic [`RRAG_Q_LENGTH*$bits(rrag_pkg::entry_state_e)-1:0] new_state_vec
);

    localparam int QL = `RRAG_Q_LENGTH;
    localparam int SW = $bits(rrag_pkg::entry_state_e);
    localparam int AW = `RRAG_ALIAS_MSB - `RRAG_ALIAS_LSB + 1;

    // opcode decode
    logic sq_all;
    logic sq_alias;

    // per-slot conditions
    logic [QL-1:0] slot_valid;
    logic [QL-1:0] alias_hit;

    always_comb begin
        sq_all   = 1'b0;
        sq_alias = 1'b0;
        case (squash_op)
            rrag_pkg::SQ_ALL:   sq_all   = 1'b1;
            rrag_pkg::SQ_ALIAS: sq_alias = 1'b1;
            // SQ_NONE and unused codes touch nothing
            default: begin
                sq_all   = 1'b0;
                sq_alias = 1'b0;
            end
        endcase
    end

    for (genvar g = 0; g < QL; g++) begin : g_slot
        // only waiting entries can be hit
        // free and already squashed slots stay as they are
        assign slot_valid[g] = (old_state_vec[g*SW +: SW] == rrag_pkg::ENT_VALID);

        // predictor alias compare
        assign alias_hit[g] = (alias_vec[g*AW +: AW] == squash_alias);

        // hit slots go squashed, others echo their old state
        assign new_state_vec[g*SW +: SW] = modify_vec[g] ? rrag_pkg::ENT_SQUASHED
                                                         : old_state_vec[g*SW +: SW];
    end

    // hit mask
    assign modify_vec = slot_valid & ({QL{sq_all}} | ({QL{sq_alias}} & alias_hit));

endmodule

//--- src/rrag_queue.sv
`include "rrag_settings.svh"

module rrag_queue (
    input  logic                                clk,
    input  logic                                arst_n,
    // push side, decode
    input  logic                                wr,
    input  logic [`RRAG_N_WIDTH-1:0]            din,
    // pop side, rename and allocate
    input  logic                                rd,
    input  logic                                clr,
    // branch mispredict squash
    input  rrag_pkg::squash_op_e                squash_op,
    input  logic [`RRAG_ALIAS_MSB-`RRAG_ALIAS_LSB:0] squash_alias,
    output logic                                full,
    output logic                                empty,
    output logic [$bits(rrag_pkg::entry_state_e)+`RRAG_N_WIDTH-1:0] dout
);

    localparam int QL = `RRAG_Q_LENGTH;
    localparam int SW = $bits(rrag_pkg::entry_state_e);
    localparam int AW = `RRAG_ALIAS_MSB - `RRAG_ALIAS_LSB + 1;

    // control to store
    logic                       write_en;
    logic                       read_en;
    logic [`RRAG_PTR_WIDTH-1:0] wr_ptr;
    logic [`RRAG_PTR_WIDTH-1:0] rd_ptr;

    // store and squash loop
    logic [QL*SW-1:0] old_state_vec;
    logic [QL*AW-1:0] alias_vec;
    logic [QL-1:0]    modify_vec;
    logic [QL*SW-1:0] new_state_vec;

    rrag_queue_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (wr),
        .rd       (rd),
        .clr      (clr),
        .write_en (write_en),
        .read_en  (read_en),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .full     (full),
        .empty    (empty)
    );

    rrag_queue_store u_store (
        .clk           (clk),
        .arst_n        (arst_n),
        .write_en      (write_en),
        .read_en       (read_en),
        .clr           (clr),
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .din           (din),
        .modify_vec    (modify_vec),
        .new_state_vec (new_state_vec),
        .old_state_vec (old_state_vec),
        .alias_vec     (alias_vec),
        .dout          (dout)
    );

    // combinational, closes the state rewrite loop within one edge
    rrag_squash_unit u_squash (
        .squash_op     (squash_op),
        .squash_alias  (squash_alias),
        .old_state_vec (old_state_vec),
        .alias_vec     (alias_vec),
        .modify_vec    (modify_vec),
        .new_state_vec (new_state_vec)
    );

endmodule

//--- sim/rrag_queue_assert.sv
module rrag_queue_assert (
    input logic clk,
    input logic arst_n,
    input logic wr,
    input logic rd,
    input logic clr,
    input logic full,
    input logic empty
);

    // sticky marks, one per property, read by the testbench
    logic fail_excl     = 1'b0;
    logic fail_reset    = 1'b0;
    logic fail_wr_empty = 1'b0;
    logic fail_wr_full  = 1'b0;
    logic fail_clr      = 1'b0;
    logic failed;

    assign failed = fail_excl | fail_reset | fail_wr_empty | fail_wr_full | fail_clr;

    // status flags exclude each other
    a_full_empty_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(full && empty)
    ) else begin
        fail_excl = 1'b1;
        $error("full and empty are high together");
    end

    // first cycle out of reset sees an empty queue
    a_reset_state: assert property (
        @(posedge clk) $rose(arst_n) |-> (empty && !full)
    ) else begin
        fail_reset = 1'b1;
        $error("queue not empty right after reset release");
    end

    // push into an empty queue shows up one edge later
    a_wr_empty: assert property (
        @(posedge clk) disable iff (!arst_n) (wr && empty && !clr) |=> !empty
    ) else begin
        fail_wr_empty = 1'b1;
        $error("empty stayed high after a write into an empty queue");
    end

    // dropped push, no pop, so still full
    a_wr_full: assert property (
        @(posedge clk) disable iff (!arst_n) (wr && full && !rd && !clr) |=> full
    ) else begin
        fail_wr_full = 1'b1;
        $error("full dropped after a write into a full queue");
    end

    // clear empties the queue in one edge
    a_clr_empty: assert property (
        @(posedge clk) disable iff (!arst_n) clr |=> empty
    ) else begin
        fail_clr = 1'b1;
        $error("queue not empty one cycle after clr");
    end

endmodule

//--- sim/rrag_queue_tb.sv
`include "rrag_settings.svh"

module rrag_queue_tb;

    localparam int NW  = `RRAG_N_WIDTH;
    localparam int QL  = `RRAG_Q_LENGTH;
    localparam int SW  = $bits(rrag_pkg::entry_state_e);
    localparam int AW  = `RRAG_ALIAS_MSB - `RRAG_ALIAS_LSB + 1;
    localparam int DW  = SW + NW;
    localparam logic [31:0] SEED = 32'h3c8d_0184;

    // run length budget
    localparam int unsigned RESET_CYCLES    = 10;
    localparam int unsigned RANDOM_CYCLES   = 200;
    localparam int unsigned DIRECTED_CYCLES = 100;
    localparam int unsigned TIMEOUT_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES + 50;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  wr;
    logic [NW-1:0]         din;
    logic                  rd;
    logic                  clr;
    rrag_pkg::squash_op_e  squash_op;
    logic [AW-1:0]         squash_alias;
    logic                  full;
    logic                  empty;
    logic [DW-1:0]         dout;

    // reference queue, head at index 0
    logic [NW-1:0]          model_payload [$];
    rrag_pkg::entry_state_e model_state [$];

    logic [31:0] rng;
    string       test_name = "reset_clear";
    int unsigned cycle_count = 0;

    rrag_queue UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr           (wr),
        .din          (din),
        .rd           (rd),
        .clr          (clr),
        .squash_op    (squash_op),
        .squash_alias (squash_alias),
        .full         (full),
        .empty        (empty),
        .dout         (dout)
    );

    bind rrag_queue rrag_queue_assert u_assert (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr),
        .rd     (rd),
        .clr    (clr),
        .full   (full),
        .empty  (empty)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run passed %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // bound property failures
    always @(negedge clk) begin
        if (UUT.u_assert.failed) begin
            fail_run("a bound assertion on the queue ports failed");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // 40 bits from two draws
    task automatic random_payload(output logic [NW-1:0] p);
        logic [31:0] hi;
        logic [31:0] lo;
        next_rand(hi);
        next_rand(lo);
        p = {hi[NW-33:0], lo};
    endtask

    // mispredict rule on the model, waiting entries only
    task automatic apply_squash(input rrag_pkg::squash_op_e op, input logic [AW-1:0] al);
        logic hit;
        for (int i = 0; i < model_state.size(); i++) begin
            hit = (op == rrag_pkg::SQ_ALL) ||
                  ((op == rrag_pkg::SQ_ALIAS) &&
                   (model_payload[i][`RRAG_ALIAS_MSB:`RRAG_ALIAS_LSB] == al));
            if ((model_state[i] == rrag_pkg::ENT_VALID) && hit) begin
                model_state[i] = rrag_pkg::ENT_SQUASHED;
            end
        end
    endtask

    // flags against model occupancy
    task automatic check_status();
        logic exp_empty;
        logic exp_full;
        exp_empty = (model_payload.size() == 0);
        exp_full  = (model_payload.size() == QL);
        if (empty !== exp_empty) begin
            fail_run($sformatf("ERROR %s empty: expected %b actual %b",
                               test_name, exp_empty, empty));
        end
        if (full !== exp_full) begin
            fail_run($sformatf("ERROR %s full: expected %b actual %b",
                               test_name, exp_full, full));
        end
    endtask

    // one clock: drive at the edge, check and update the model mid-cycle
    task automatic cycle(input logic w, input logic [NW-1:0] d, input logic r,
                         input logic c, input rrag_pkg::squash_op_e op,
                         input logic [AW-1:0] al);
        logic          do_pop;
        logic          do_push;
        logic [DW-1:0] exp_word;
        @(posedge clk);
        wr           <= w;
        din          <= d;
        rd           <= r;
        clr          <= c;
        squash_op    <= op;
        squash_alias <= al;
        @(negedge clk);
        check_status();
        if (c) begin
            model_payload.delete();
            model_state.delete();
        end else begin
            // room is judged before the pop of the same edge
            do_pop  = r && (model_payload.size() > 0);
            do_push = w && (model_payload.size() < QL);
            if (do_pop) begin
                exp_word = {model_state[0], model_payload[0]};
                if (dout !== exp_word) begin
                    fail_run($sformatf("ERROR %s dout: expected %h actual %h",
                                       test_name, exp_word, dout));
                end
                void'(model_payload.pop_front());
                void'(model_state.pop_front());
            end
            // popped entry gone, new entry not yet in
            apply_squash(op, al);
            if (do_push) begin
                model_payload.push_back(d);
                model_state.push_back(rrag_pkg::ENT_VALID);
            end
        end
    endtask

    task automatic idle();
        cycle(1'b0, '0, 1'b0, 1'b0, rrag_pkg::SQ_NONE, '0);
    endtask

    task automatic push(input logic [NW-1:0] p);
        cycle(1'b1, p, 1'b0, 1'b0, rrag_pkg::SQ_NONE, '0);
    endtask

    // pop until the model is empty, then see empty rise
    task automatic drain();
        while (model_payload.size() > 0) begin
            cycle(1'b0, '0, 1'b1, 1'b0, rrag_pkg::SQ_NONE, '0);
        end
        idle();
    endtask

    initial begin
        logic [NW-1:0] p;
        logic [31:0]   r;
        logic [AW-1:0] alias_a;
        logic [AW-1:0] alias_b;
        arst_n       <= 1'b0;
        wr           <= 1'b0;
        din          <= '0;
        rd           <= 1'b0;
        clr          <= 1'b0;
        squash_op    <= rrag_pkg::SQ_NONE;
        squash_alias <= '0;
        rng = SEED;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        idle();

        // clear mid-stream, beats push, pop and squash
        repeat (3) begin
            random_payload(p);
            push(p);
        end
        random_payload(p);
        cycle(1'b1, p, 1'b1, 1'b1, rrag_pkg::SQ_ALL, '0);
        idle();
        idle();

        // push-heavy random mix, no squash
        test_name = "in_order";
        repeat (RANDOM_CYCLES) begin
            next_rand(r);
            random_payload(p);
            cycle(r[0] | r[3], p, r[1], 1'b0, rrag_pkg::SQ_NONE, '0);
        end
        drain();

        // ninth push is dropped
        test_name = "full_backpressure";
        repeat (QL + 1) begin
            random_payload(p);
            push(p);
        end
        drain();

        // flush with a push on the same edge
        test_name = "squash_all";
        repeat (5) begin
            random_payload(p);
            push(p);
        end
        random_payload(p);
        cycle(1'b1, p, 1'b0, 1'b0, rrag_pkg::SQ_ALL, '0);
        drain();

        // two aliases, only one flushed
        test_name = "squash_alias";
        next_rand(r);
        alias_a = r[AW-1:0];
        alias_b = ~alias_a;
        for (int i = 0; i < QL; i++) begin
            next_rand(r);
            random_payload(p);
            p[`RRAG_ALIAS_MSB:`RRAG_ALIAS_LSB] = ((i == 0) || (r[0] && i != 1)) ? alias_a
                                                                                 : alias_b;
            push(p);
        end
        cycle(1'b0, '0, 1'b0, 1'b0, rrag_pkg::SQ_ALIAS, alias_a);
        drain();

        // head matches but is popped on the squash edge
        test_name = "squash_pop_race";
        for (int i = 0; i < 6; i++) begin
            random_payload(p);
            p[`RRAG_ALIAS_MSB:`RRAG_ALIAS_LSB] = (i == 2) ? alias_b : alias_a;
            push(p);
        end
        cycle(1'b0, '0, 1'b1, 1'b0, rrag_pkg::SQ_ALIAS, alias_a);
        drain();
        idle();

        if (UUT.u_assert.failed) begin
            fail_run("a bound assertion on the queue ports failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- rrag_queue.f
+incdir+src
src/rrag_pkg.sv
src/rrag_queue_ctrl.sv
src/rrag_queue_store.sv
src/rrag_squash_unit.sv
src/rrag_queue.sv
sim/rrag_queue_assert.sv
sim/rrag_queue_tb.sv

//--- run.sh
#!/bin/sh
# build and run the queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module rrag_queue_tb -f rrag_queue.f -o rrag_queue_sim

# keep going after a failing run so the output can be searched
out=$(./obj_dir/rrag_queue_sim +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF 'STATUS: PASS'; then
    exit 0
fi
exit 1
